// ==== hw/zxuno_io_defines.svh ====
`ifndef ZXUNO_IO_DEFINES_SVH
`define ZXUNO_IO_DEFINES_SVH

////////////////////
// I/O port map
////////////////////

// ZX-Uno register select and data ports, full 16-bit decode
`define ZXUNO_ADDR_PORT 16'hFC3B
`define ZXUNO_DATA_PORT 16'hFD3B

// Kempston joystick, low address byte only
`define KEMPSTON_PORT 8'd31

////////////////////
// ZX-Uno register numbers
////////////////////

`define REG_MASTERCONF 8'h00
`define REG_SCANCODE 8'h04
`define REG_JOYCONF 8'h06

// Boot mode on, everything else off
`define MASTERCONF_RESET 8'h80
// DB9 and keypad joystick both on, fire not inverted
`define JOYCONF_RESET 8'hC0

////////////////////
// Mixer weights
////////////////////

`define MIX_SPK 8'd64
`define MIX_EAR 8'd32
`define MIX_MIC 8'd16

`endif

// ==== hw/zxuno_io_pkg.sv ====
package zxuno_io_pkg;

   // Z80 bus
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0] cpu_data_t;

   // Register number held in the ZX-Uno address port
   typedef logic [7:0] zxreg_t;

   // Kempston bit order, active high
   // Bit 4 fire, 3 up, 2 down, 1 left, 0 right
   typedef logic [4:0] joy_t;

   // Register 0, seen by memory controller and ULA
   typedef struct packed {
      logic in_boot_mode;
      logic disable_contention;
      logic [1:0] timing_ula;
      logic issue2_keyboard;
      logic [2:0] reserved;
   } masterconf_t;

   // Register 6, joystick sources and fire polarity
   typedef struct packed {
      logic db9_enable;
      logic kbd_joy_enable;
      logic fire_invert;
      logic [4:0] reserved;
   } joyconf_t;

   // Mixed audio level and AY channel levels
   typedef logic [7:0] audio_level_t;

endpackage

// ==== hw/cfg_reg.sv ====
`timescale 1ns/100ps

module cfg_reg #(
   parameter type payload_t = logic [7:0],
   parameter zxuno_io_pkg::zxreg_t REG_NUM = '0,
   parameter payload_t RESET_VALUE = '0
) (
   input logic clk,
   input logic reset,
   input zxuno_io_pkg::zxreg_t zx_addr,
   input logic reg_rd,
   input logic reg_wr,
   input zxuno_io_pkg::cpu_data_t cpu_dout,
   output payload_t value,
   output zxuno_io_pkg::cpu_data_t dout,
   output logic oe_n
);

   logic selected;

   // This register is the one behind the data port
   assign selected = (zx_addr == REG_NUM);

   // Write lands at the end of the data-port cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         value <= RESET_VALUE;
      end else if (reg_wr && selected) begin
         value <= payload_t'(cpu_dout);
      end
   end

   // Payload flattened back onto the byte bus
   assign dout = zxuno_io_pkg::cpu_data_t'(value);
   assign oe_n = !(reg_rd && selected);

endmodule

// ==== hw/zxuno_regs.sv ====
`timescale 1ns/100ps
`include "zxuno_io_defines.svh"

module zxuno_regs (
   input logic clk,
   input logic reset,
   input zxuno_io_pkg::cpu_addr_t cpu_addr,
   input logic iorq_n,
   input logic rd_n,
   input logic wr_n,
   input zxuno_io_pkg::cpu_data_t cpu_dout,
   output zxuno_io_pkg::zxreg_t zx_addr,
   output zxuno_io_pkg::cpu_data_t addr_dout,
   output logic addr_oe_n,
   output logic reg_rd,
   output logic reg_wr
);

   ////////////////////
   // Port decode
   ////////////////////

   logic addr_port;
   logic data_port;
   logic io_rd;
   logic io_wr;

   // Both ports need all 16 address bits
   assign addr_port = (cpu_addr == `ZXUNO_ADDR_PORT);
   assign data_port = (cpu_addr == `ZXUNO_DATA_PORT);

   // IO read and write strobes
   assign io_rd = !iorq_n && !rd_n;
   assign io_wr = !iorq_n && !wr_n;

   ////////////////////
   // Register select latch
   ////////////////////

   // Loaded at the edge closing the write cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         zx_addr <= '0;
      end else if (io_wr && addr_port) begin
         zx_addr <= cpu_dout;
      end
   end

   // Readback of the selected register number
   assign addr_dout = zx_addr;
   assign addr_oe_n = !(io_rd && addr_port);

   ////////////////////
   // Data port strobes
   ////////////////////

   // Combinational for the whole access cycle
   // Register blocks match zx_addr themselves
   assign reg_rd = io_rd && data_port;
   assign reg_wr = io_wr && data_port;

endmodule

// ==== hw/kempston_port.sv ====
`timescale 1ns/100ps
`include "zxuno_io_defines.svh"

module kempston_port (
   input logic clk,
   input logic reset,
   input zxuno_io_pkg::cpu_addr_t cpu_addr,
   input logic iorq_n,
   input logic rd_n,
   input zxuno_io_pkg::joy_t joy_db9_n,
   input zxuno_io_pkg::joy_t kbd_joy,
   input zxuno_io_pkg::joyconf_t joyconf,
   output zxuno_io_pkg::joy_t joy_value,
   output logic kemp_oe_n
);

   zxuno_io_pkg::joy_t db9_bits;
   zxuno_io_pkg::joy_t kbd_bits;
   zxuno_io_pkg::joy_t merged;

   // DB9 pins are active low, flip to Kempston polarity
   assign db9_bits = joyconf.db9_enable ? ~joy_db9_n : '0;
   // Numeric keypad joystick
   assign kbd_bits = joyconf.kbd_joy_enable ? kbd_joy : '0;

   // Fire polarity applied after both sources are merged
   assign merged = (db9_bits | kbd_bits) ^ {joyconf.fire_invert, 4'b0000};

   // One cycle sample of the pins
   always_ff @(posedge clk) begin
      if (reset) begin
         joy_value <= '0;
      end else begin
         joy_value <= merged;
      end
   end

   // Partial decode, only A7:A0 looked at
   assign kemp_oe_n = !(!iorq_n && !rd_n && cpu_addr[7:0] == `KEMPSTON_PORT);

endmodule

// ==== hw/io_bus_decode.sv ====
`timescale 1ns/100ps
`include "zxuno_io_defines.svh"

module io_bus_decode (
   input zxuno_io_pkg::cpu_addr_t cpu_addr,
   input logic iorq_n,
   input logic mreq_n,
   input logic rd_n,
   input logic wr_n,
   input zxuno_io_pkg::cpu_data_t mem_dout,
   input logic mem_oe_n,
   input zxuno_io_pkg::cpu_data_t ay_dout,
   input logic ay_oe_n,
   input zxuno_io_pkg::joy_t joy_value,
   input logic kemp_oe_n,
   input zxuno_io_pkg::cpu_data_t addr_dout,
   input logic addr_oe_n,
   input zxuno_io_pkg::cpu_data_t mc_dout,
   input logic mc_oe_n,
   input zxuno_io_pkg::cpu_data_t jc_dout,
   input logic jc_oe_n,
   input zxuno_io_pkg::cpu_data_t scancode,
   input zxuno_io_pkg::cpu_data_t ula_dout,
   input zxuno_io_pkg::zxreg_t zx_addr,
   input logic reg_rd,
   output zxuno_io_pkg::cpu_data_t cpu_din,
   output logic ay_bdir,
   output logic ay_bc1
);

   ////////////////////
   // AY chip select
   ////////////////////

   logic io_access;
   logic ay_port;
   logic scancode_rd;

   // Real IO cycle with a read or write strobe
   // Interrupt acknowledge has iorq_n low but neither strobe
   assign io_access = !iorq_n && mreq_n && (!rd_n || !wr_n);

   // A15 high, A1:A0 = 01 covers both FFFD and BFFD
   assign ay_port = cpu_addr[15] && (cpu_addr[1:0] == 2'b01);

   // BDIR for data and address writes
   assign ay_bdir = io_access && ay_port && !wr_n;
   // BC1 only on FFFD, register select or read
   assign ay_bc1 = io_access && ay_port && cpu_addr[14];

   ////////////////////
   // CPU read mux
   ////////////////////

   // Scancode has no block of its own
   assign scancode_rd = reg_rd && (zx_addr == `REG_SCANCODE);

   // Fixed priority, ULA when nobody claims the bus
   always_comb begin
      if (!mem_oe_n) begin
         cpu_din = mem_dout;
      end else if (!ay_oe_n) begin
         cpu_din = ay_dout;
      end else if (!kemp_oe_n) begin
         cpu_din = {3'b000, joy_value};
      end else if (!addr_oe_n) begin
         cpu_din = addr_dout;
      end else if (!mc_oe_n) begin
         cpu_din = mc_dout;
      end else if (!jc_oe_n) begin
         cpu_din = jc_dout;
      end else if (scancode_rd) begin
         cpu_din = scancode;
      end else begin
         cpu_din = ula_dout;
      end
   end

endmodule

// ==== hw/audio_mixer.sv ====
`timescale 1ns/100ps
`include "zxuno_io_defines.svh"

module audio_mixer (
   input logic clk,
   input logic reset,
   input logic mic,
   input logic spk,
   input logic ear,
   input zxuno_io_pkg::audio_level_t ay1_audio,
   input zxuno_io_pkg::audio_level_t ay2_audio,
   output logic audio_out
);

   ////////////////////
   // Level
   ////////////////////

   zxuno_io_pkg::audio_level_t ay_sum;
   zxuno_io_pkg::audio_level_t beeper_sum;
   zxuno_io_pkg::audio_level_t level;

   // Each AY scaled to a quarter, at most 63 each
   assign ay_sum = {2'b00, ay1_audio[7:2]} + {2'b00, ay2_audio[7:2]};

   // Beeper, tape in and tape out, at most 112 together
   assign beeper_sum = (spk ? `MIX_SPK : 8'd0)
                     + (ear ? `MIX_EAR : 8'd0)
                     + (mic ? `MIX_MIC : 8'd0);

   // Peak 238, no overflow into a ninth bit
   assign level = ay_sum + beeper_sum;

   ////////////////////
   // Sigma-delta DAC
   ////////////////////

   zxuno_io_pkg::audio_level_t acc;
   logic [8:0] acc_next;

   // Carry out is the one-bit density
   assign acc_next = {1'b0, acc} + {1'b0, level};

   // Free-running, updates every clk
   // Constant level gives exactly level carries per 256 cycles
   always_ff @(posedge clk) begin
      if (reset) begin
         acc <= '0;
         audio_out <= 1'b0;
      end else begin
         acc <= acc_next[7:0];
         audio_out <= acc_next[8];
      end
   end

endmodule

// ==== hw/zxuno_io.sv ====
`timescale 1ns/100ps
`include "zxuno_io_defines.svh"

module zxuno_io (
   input logic clk,
   input logic reset,
   // Z80 bus
   input zxuno_io_pkg::cpu_addr_t cpu_addr,
   input zxuno_io_pkg::cpu_data_t cpu_dout,
   input logic iorq_n,
   input logic rd_n,
   input logic wr_n,
   input logic mreq_n,
   output zxuno_io_pkg::cpu_data_t cpu_din,
   // External read sources
   input zxuno_io_pkg::cpu_data_t mem_dout,
   input logic mem_oe_n,
   input zxuno_io_pkg::cpu_data_t ula_dout,
   input zxuno_io_pkg::cpu_data_t ay_dout,
   input logic ay_oe_n,
   // AY bus control
   output logic ay_bdir,
   output logic ay_bc1,
   // Joystick and keyboard
   input zxuno_io_pkg::joy_t joy_db9_n,
   input zxuno_io_pkg::joy_t kbd_joy,
   input zxuno_io_pkg::cpu_data_t scancode,
   // Sound
   input logic mic,
   input logic spk,
   input logic ear,
   input zxuno_io_pkg::audio_level_t ay1_audio,
   input zxuno_io_pkg::audio_level_t ay2_audio,
   output logic audio_out,
   // To memory controller and ULA
   output zxuno_io_pkg::masterconf_t masterconf
);

   ////////////////////
   // Internal wires
   ////////////////////

   // ZX-Uno register port
   zxuno_io_pkg::zxreg_t zx_addr;
   zxuno_io_pkg::cpu_data_t addr_dout;
   logic addr_oe_n;
   logic reg_rd;
   logic reg_wr;

   // Config register readback
   zxuno_io_pkg::cpu_data_t mc_dout;
   logic mc_oe_n;
   zxuno_io_pkg::joyconf_t joyconf;
   zxuno_io_pkg::cpu_data_t jc_dout;
   logic jc_oe_n;

   // Kempston
   zxuno_io_pkg::joy_t joy_value;
   logic kemp_oe_n;

   ////////////////////
   // Register access
   ////////////////////

   zxuno_regs i_zxuno_regs (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .iorq_n(iorq_n),
      .rd_n(rd_n),
      .wr_n(wr_n),
      .cpu_dout(cpu_dout),
      .zx_addr(zx_addr),
      .addr_dout(addr_dout),
      .addr_oe_n(addr_oe_n),
      .reg_rd(reg_rd),
      .reg_wr(reg_wr)
   );

   // Register 0
   cfg_reg #(
      .payload_t(zxuno_io_pkg::masterconf_t),
      .REG_NUM(`REG_MASTERCONF),
      .RESET_VALUE(`MASTERCONF_RESET)
   ) i_masterconf (
      .clk(clk),
      .reset(reset),
      .zx_addr(zx_addr),
      .reg_rd(reg_rd),
      .reg_wr(reg_wr),
      .cpu_dout(cpu_dout),
      .value(masterconf),
      .dout(mc_dout),
      .oe_n(mc_oe_n)
   );

   // Register 6
   cfg_reg #(
      .payload_t(zxuno_io_pkg::joyconf_t),
      .REG_NUM(`REG_JOYCONF),
      .RESET_VALUE(`JOYCONF_RESET)
   ) i_joyconf (
      .clk(clk),
      .reset(reset),
      .zx_addr(zx_addr),
      .reg_rd(reg_rd),
      .reg_wr(reg_wr),
      .cpu_dout(cpu_dout),
      .value(joyconf),
      .dout(jc_dout),
      .oe_n(jc_oe_n)
   );

   ////////////////////
   // Joystick, bus, audio
   ////////////////////

   kempston_port i_kempston_port (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .iorq_n(iorq_n),
      .rd_n(rd_n),
      .joy_db9_n(joy_db9_n),
      .kbd_joy(kbd_joy),
      .joyconf(joyconf),
      .joy_value(joy_value),
      .kemp_oe_n(kemp_oe_n)
   );

   io_bus_decode i_io_bus_decode (
      .cpu_addr(cpu_addr),
      .iorq_n(iorq_n),
      .mreq_n(mreq_n),
      .rd_n(rd_n),
      .wr_n(wr_n),
      .mem_dout(mem_dout),
      .mem_oe_n(mem_oe_n),
      .ay_dout(ay_dout),
      .ay_oe_n(ay_oe_n),
      .joy_value(joy_value),
      .kemp_oe_n(kemp_oe_n),
      .addr_dout(addr_dout),
      .addr_oe_n(addr_oe_n),
      .mc_dout(mc_dout),
      .mc_oe_n(mc_oe_n),
      .jc_dout(jc_dout),
      .jc_oe_n(jc_oe_n),
      .scancode(scancode),
      .ula_dout(ula_dout),
      .zx_addr(zx_addr),
      .reg_rd(reg_rd),
      .cpu_din(cpu_din),
      .ay_bdir(ay_bdir),
      .ay_bc1(ay_bc1)
   );

   audio_mixer i_audio_mixer (
      .clk(clk),
      .reset(reset),
      .mic(mic),
      .spk(spk),
      .ear(ear),
      .ay1_audio(ay1_audio),
      .ay2_audio(ay2_audio),
      .audio_out(audio_out)
   );

endmodule

// ==== dv/zxuno_io_sva.sv ====
`timescale 1ns/100ps

module zxuno_io_sva (
   input logic clk,
   input logic reset,
   input logic reg_rd,
   input logic reg_wr,
   input logic addr_oe_n,
   input logic mc_oe_n,
   input logic jc_oe_n,
   input logic kemp_oe_n,
   input logic ay_bdir,
   input logic wr_n
);

   // Failure tally, read back by the testbench
   int assert_errors = 0;

   ////////////////////
   // Strobes
   ////////////////////

   // Data port is either read or written, never both
   rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(reg_rd && reg_wr))
   else begin
      $error("reg_rd and reg_wr high together");
      assert_errors = assert_errors + 1;
   end

   // BDIR only during a CPU write
   bdir_needs_write: assert property (@(posedge clk) disable iff (reset)
      ay_bdir |-> !wr_n)
   else begin
      $error("ay_bdir high without wr_n low");
      assert_errors = assert_errors + 1;
   end

   ////////////////////
   // Read mux
   ////////////////////

   // Internal read sources never overlap
   one_internal_source: assert property (@(posedge clk) disable iff (reset)
      $countones({!addr_oe_n, !mc_oe_n, !jc_oe_n, !kemp_oe_n}) <= 1)
   else begin
      $error("more than one internal oe_n low");
      assert_errors = assert_errors + 1;
   end

endmodule

bind zxuno_io zxuno_io_sva i_zxuno_io_sva (
   .clk(clk),
   .reset(reset),
   .reg_rd(reg_rd),
   .reg_wr(reg_wr),
   .addr_oe_n(addr_oe_n),
   .mc_oe_n(mc_oe_n),
   .jc_oe_n(jc_oe_n),
   .kemp_oe_n(kemp_oe_n),
   .ay_bdir(ay_bdir),
   .wr_n(wr_n)
);

// ==== dv/zxuno_io_tb.sv ====
`timescale 1ns/100ps
`include "zxuno_io_defines.svh"

module zxuno_io_tb;

   localparam int HALF_PERIOD = 10;
   localparam int RESET_CYCLES = 4;
   localparam int RESET_TIMEOUT = 20;

   ////////////////////
   // DUT signals
   ////////////////////

   logic clk;
   logic reset;
   zxuno_io_pkg::cpu_addr_t cpu_addr;
   zxuno_io_pkg::cpu_data_t cpu_dout;
   logic iorq_n;
   logic rd_n;
   logic wr_n;
   logic mreq_n;
   zxuno_io_pkg::cpu_data_t cpu_din;
   zxuno_io_pkg::cpu_data_t mem_dout;
   logic mem_oe_n;
   zxuno_io_pkg::cpu_data_t ula_dout;
   zxuno_io_pkg::cpu_data_t ay_dout;
   logic ay_oe_n;
   logic ay_bdir;
   logic ay_bc1;
   zxuno_io_pkg::joy_t joy_db9_n;
   zxuno_io_pkg::joy_t kbd_joy;
   zxuno_io_pkg::cpu_data_t scancode;
   logic mic;
   logic spk;
   logic ear;
   zxuno_io_pkg::audio_level_t ay1_audio;
   zxuno_io_pkg::audio_level_t ay2_audio;
   logic audio_out;
   zxuno_io_pkg::masterconf_t masterconf;

   integer seed;
   int data_errors;
   int joy_errors;
   int level_errors;
   int bit_errors;
   int total_errors;

   // Reference model state
   zxuno_io_pkg::zxreg_t model_zx_addr;
   zxuno_io_pkg::masterconf_t model_mc;
   zxuno_io_pkg::joyconf_t model_jc;

   zxuno_io i_zxuno_io (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .cpu_dout(cpu_dout),
      .iorq_n(iorq_n),
      .rd_n(rd_n),
      .wr_n(wr_n),
      .mreq_n(mreq_n),
      .cpu_din(cpu_din),
      .mem_dout(mem_dout),
      .mem_oe_n(mem_oe_n),
      .ula_dout(ula_dout),
      .ay_dout(ay_dout),
      .ay_oe_n(ay_oe_n),
      .ay_bdir(ay_bdir),
      .ay_bc1(ay_bc1),
      .joy_db9_n(joy_db9_n),
      .kbd_joy(kbd_joy),
      .scancode(scancode),
      .mic(mic),
      .spk(spk),
      .ear(ear),
      .ay1_audio(ay1_audio),
      .ay2_audio(ay2_audio),
      .audio_out(audio_out),
      .masterconf(masterconf)
   );

   // 20 ns clock
   always #(HALF_PERIOD) clk = !clk;

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_data(input string name, input zxuno_io_pkg::cpu_data_t got,
                             input zxuno_io_pkg::cpu_data_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
         data_errors++;
      end
   endtask

   task automatic check_joy(input string name, input zxuno_io_pkg::joy_t got,
                            input zxuno_io_pkg::joy_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
         joy_errors++;
      end
   endtask

   task automatic check_level(input string name, input zxuno_io_pkg::audio_level_t got,
                              input zxuno_io_pkg::audio_level_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
         level_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
         bit_errors++;
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Kempston rule, DB9 inverted and gated, keypad ORed, fire flipped last
   function automatic zxuno_io_pkg::joy_t expected_joy(input zxuno_io_pkg::joy_t db9_n,
                                                       input zxuno_io_pkg::joy_t kbd,
                                                       input zxuno_io_pkg::joyconf_t cfg);
      zxuno_io_pkg::joy_t bits;
      bits = '0;
      if (cfg.db9_enable) bits = bits | ~db9_n;
      if (cfg.kbd_joy_enable) bits = bits | kbd;
      if (cfg.fire_invert) bits[4] = !bits[4];
      return bits;
   endfunction

   // Data port read for the selected register
   function automatic zxuno_io_pkg::cpu_data_t expected_data_port();
      if (model_zx_addr == `REG_MASTERCONF) return model_mc;
      if (model_zx_addr == `REG_JOYCONF) return model_jc;
      if (model_zx_addr == `REG_SCANCODE) return scancode;
      return ula_dout;
   endfunction

   // Quarter of each AY plus beeper weights
   function automatic zxuno_io_pkg::audio_level_t expected_level(
         input logic m, input logic s, input logic e,
         input zxuno_io_pkg::audio_level_t a1, input zxuno_io_pkg::audio_level_t a2);
      int sum;
      sum = a1 / 4 + a2 / 4;
      if (s) sum += `MIX_SPK;
      if (e) sum += `MIX_EAR;
      if (m) sum += `MIX_MIC;
      return zxuno_io_pkg::audio_level_t'(sum);
   endfunction

   ////////////////////
   // CPU bus tasks
   ////////////////////

   // One-cycle write, register loads at the middle rising edge
   task automatic io_write(input zxuno_io_pkg::cpu_addr_t addr,
                           input zxuno_io_pkg::cpu_data_t data);
      @(negedge clk);
      cpu_addr = addr;
      cpu_dout = data;
      iorq_n = 1'b0;
      wr_n = 1'b0;
      @(negedge clk);
      iorq_n = 1'b1;
      wr_n = 1'b1;
   endtask

   // One-cycle read, data sampled mid low phase
   task automatic io_read(input zxuno_io_pkg::cpu_addr_t addr,
                          output zxuno_io_pkg::cpu_data_t data);
      @(negedge clk);
      cpu_addr = addr;
      iorq_n = 1'b0;
      rd_n = 1'b0;
      #(HALF_PERIOD / 2);
      data = cpu_din;
      @(negedge clk);
      iorq_n = 1'b1;
      rd_n = 1'b1;
   endtask

   task automatic select_reg(input zxuno_io_pkg::zxreg_t num);
      io_write(`ZXUNO_ADDR_PORT, num);
      model_zx_addr = num;
   endtask

   // Register 0 must come out of reset at its reset value
   task automatic wait_for_reset_values();
      int cycles;
      cycles = 0;
      while (masterconf !== `MASTERCONF_RESET && cycles < RESET_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (masterconf !== `MASTERCONF_RESET) begin
         $display("Timed out waiting for masterconf to reach its reset value");
         $display("Test FAILED");
         $finish;
      end
   endtask

   ////////////////////
   // Test sections
   ////////////////////

   task automatic test_after_reset();
      zxuno_io_pkg::cpu_data_t got;
      io_read(`ZXUNO_ADDR_PORT, got);
      check_data("cpu_din (address port after reset)", got, 8'h00);
      select_reg(`REG_MASTERCONF);
      io_read(`ZXUNO_DATA_PORT, got);
      check_data("cpu_din (masterconf after reset)", got, `MASTERCONF_RESET);
      select_reg(`REG_JOYCONF);
      io_read(`ZXUNO_DATA_PORT, got);
      check_data("cpu_din (joyconf after reset)", got, `JOYCONF_RESET);
      check_data("masterconf", masterconf, `MASTERCONF_RESET);
   endtask

   task automatic test_register_traffic();
      zxuno_io_pkg::cpu_data_t got;
      zxuno_io_pkg::cpu_data_t data;
      zxuno_io_pkg::zxreg_t num;
      int kind;
      for (int i = 0; i < 40; i++) begin
         kind = $unsigned($random(seed)) % 4;
         case (kind)
            0: num = `REG_MASTERCONF;
            1: num = `REG_SCANCODE;
            2: num = `REG_JOYCONF;
            default: num = $random(seed);
         endcase
         select_reg(num);
         io_read(`ZXUNO_ADDR_PORT, got);
         check_data("cpu_din (address port)", got, model_zx_addr);
         // Unknown numbers swallow the write
         data = $random(seed);
         io_write(`ZXUNO_DATA_PORT, data);
         if (model_zx_addr == `REG_MASTERCONF) model_mc = zxuno_io_pkg::masterconf_t'(data);
         if (model_zx_addr == `REG_JOYCONF) model_jc = zxuno_io_pkg::joyconf_t'(data);
         scancode = $random(seed);
         ula_dout = $random(seed);
         io_read(`ZXUNO_DATA_PORT, got);
         check_data("cpu_din (data port)", got, expected_data_port());
         check_data("masterconf", masterconf, model_mc);
      end
   endtask

   task automatic test_kempston();
      zxuno_io_pkg::cpu_data_t got;
      zxuno_io_pkg::cpu_data_t data;
      zxuno_io_pkg::joy_t exp;
      logic [7:0] hi;
      for (int i = 0; i < 30; i++) begin
         data = $random(seed);
         select_reg(`REG_JOYCONF);
         io_write(`ZXUNO_DATA_PORT, data);
         model_jc = zxuno_io_pkg::joyconf_t'(data);
         // New pins, sampled before the read cycle
         joy_db9_n = $random(seed);
         kbd_joy = $random(seed);
         exp = expected_joy(joy_db9_n, kbd_joy, model_jc);
         hi = $random(seed);
         io_read({hi, `KEMPSTON_PORT}, got);
         check_joy("cpu_din[4:0] (Kempston)", got[4:0], exp);
         check_data("cpu_din (Kempston)", got, {3'b000, exp});
      end
   endtask

   task automatic test_read_priority();
      zxuno_io_pkg::cpu_data_t got;
      zxuno_io_pkg::cpu_data_t exp;
      zxuno_io_pkg::cpu_addr_t addr;
      logic [7:0] hi;
      int kind;
      for (int i = 0; i < 40; i++) begin
         kind = $unsigned($random(seed)) % 4;
         hi = $random(seed);
         mem_dout = $random(seed);
         ay_dout = $random(seed);
         ula_dout = $random(seed);
         mem_oe_n = $random(seed);
         ay_oe_n = $random(seed);
         // Port FE stands for an address nobody in the hub claims
         case (kind)
            0: addr = `ZXUNO_ADDR_PORT;
            1: addr = `ZXUNO_DATA_PORT;
            2: addr = {hi, `KEMPSTON_PORT};
            default: addr = {hi, 8'hFE};
         endcase
         if (!mem_oe_n) exp = mem_dout;
         else if (!ay_oe_n) exp = ay_dout;
         else if (kind == 0) exp = model_zx_addr;
         else if (kind == 1) exp = expected_data_port();
         else if (kind == 2) exp = {3'b000, expected_joy(joy_db9_n, kbd_joy, model_jc)};
         else exp = ula_dout;
         io_read(addr, got);
         check_data("cpu_din (priority)", got, exp);
         mem_oe_n = 1'b1;
         ay_oe_n = 1'b1;
      end
   endtask

   task automatic test_ay_decode();
      zxuno_io_pkg::cpu_addr_t addr;
      logic io_rd;
      logic io_wr;
      logic exp_bdir;
      logic exp_bc1;
      int kind;
      for (int i = 0; i < 60; i++) begin
         addr = $random(seed);
         // Keep clear of the ZX-Uno ports
         if (addr[7:0] == 8'h3B) addr[7:0] = 8'h3D;
         kind = $unsigned($random(seed)) % 3;
         @(negedge clk);
         cpu_addr = addr;
         iorq_n = $random(seed);
         rd_n = (kind != 1);
         wr_n = (kind != 2);
         #(HALF_PERIOD / 2);
         io_rd = !iorq_n && !rd_n;
         io_wr = !iorq_n && !wr_n;
         // Writes to FFFD and BFFD raise BDIR, any access to FFFD raises BC1
         exp_bdir = io_wr && addr[15] && addr[1:0] == 2'b01;
         exp_bc1 = (io_rd || io_wr) && addr[15:14] == 2'b11 && addr[1:0] == 2'b01;
         check_bit("ay_bdir", ay_bdir, exp_bdir);
         check_bit("ay_bc1", ay_bc1, exp_bc1);
         @(negedge clk);
         iorq_n = 1'b1;
         rd_n = 1'b1;
         wr_n = 1'b1;
      end
   endtask

   task automatic test_mixer();
      zxuno_io_pkg::audio_level_t exp;
      int ones;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         mic = $random(seed);
         spk = $random(seed);
         ear = $random(seed);
         ay1_audio = $random(seed);
         ay2_audio = $random(seed);
         exp = expected_level(mic, spk, ear, ay1_audio, ay2_audio);
         // Let the registered output catch up with the new level
         @(negedge clk);
         ones = 0;
         repeat (256) begin
            @(negedge clk);
            if (audio_out) ones++;
         end
         check_level("audio_out ones", zxuno_io_pkg::audio_level_t'(ones), exp);
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      seed = 18314;
      data_errors = 0;
      joy_errors = 0;
      level_errors = 0;
      bit_errors = 0;
      clk = 1'b0;
      reset = 1'b1;
      cpu_addr = '0;
      cpu_dout = '0;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      mreq_n = 1'b1;
      mem_dout = '0;
      mem_oe_n = 1'b1;
      ula_dout = '0;
      ay_dout = '0;
      ay_oe_n = 1'b1;
      joy_db9_n = '1;
      kbd_joy = '0;
      scancode = '0;
      mic = 1'b0;
      spk = 1'b0;
      ear = 1'b0;
      ay1_audio = '0;
      ay2_audio = '0;
      model_zx_addr = '0;
      model_mc = `MASTERCONF_RESET;
      model_jc = `JOYCONF_RESET;

      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      wait_for_reset_values();

      test_after_reset();
      test_register_traffic();
      test_kempston();
      test_read_priority();
      test_ay_decode();
      test_mixer();

      total_errors = data_errors + joy_errors + level_errors + bit_errors
                   + i_zxuno_io.i_zxuno_io_sva.assert_errors;
      $display("Errors: data %0d, joystick %0d, level %0d, decode %0d, assertions %0d",
               data_errors, joy_errors, level_errors, bit_errors,
               i_zxuno_io.i_zxuno_io_sva.assert_errors);
      if (total_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== zxuno_io.f ====
+incdir+hw
hw/zxuno_io_pkg.sv
hw/cfg_reg.sv
hw/zxuno_regs.sv
hw/kempston_port.sv
hw/io_bus_decode.sv
hw/audio_mixer.sv
hw/zxuno_io.sv
dv/zxuno_io_sva.sv
dv/zxuno_io_tb.sv
